/* source/ialu_pkg.sv */
/*
 * Integer ALU shared definitions
 * Word width, command codes, divider FSM states and the structs
 * passed between the main ALU and the divider blocks
 */
package ialu_pkg;

//--------------------------------------------------------------------------
// Widths and basic types
//--------------------------------------------------------------------------
localparam int XLEN = 32;                       // Data word width

typedef logic [XLEN-1:0] xlen_t;                // Data word
typedef logic [4:0]      shamt_t;               // Shift amount
typedef logic [4:0]      ialu_cmd_t;            // ALU command code

// One-hot start of the divider iteration counter
localparam xlen_t DIV_CNT_INIT = xlen_t'(1) << (XLEN - 2);

//--------------------------------------------------------------------------
// Command codes
//--------------------------------------------------------------------------
localparam ialu_cmd_t CMD_NONE = 5'd0;          // No operation
localparam ialu_cmd_t CMD_ADD  = 5'd1;
localparam ialu_cmd_t CMD_SUB  = 5'd2;
localparam ialu_cmd_t CMD_AND  = 5'd3;
localparam ialu_cmd_t CMD_OR   = 5'd4;
localparam ialu_cmd_t CMD_XOR  = 5'd5;
localparam ialu_cmd_t CMD_LT   = 5'd6;          // Signed less than
localparam ialu_cmd_t CMD_LTU  = 5'd7;          // Unsigned less than
localparam ialu_cmd_t CMD_EQ   = 5'd8;
localparam ialu_cmd_t CMD_NE   = 5'd9;
localparam ialu_cmd_t CMD_GE   = 5'd10;         // Signed greater or equal
localparam ialu_cmd_t CMD_GEU  = 5'd11;         // Unsigned greater or equal
localparam ialu_cmd_t CMD_SLL  = 5'd12;
localparam ialu_cmd_t CMD_SRL  = 5'd13;
localparam ialu_cmd_t CMD_SRA  = 5'd14;
localparam ialu_cmd_t CMD_DIV  = 5'd15;
localparam ialu_cmd_t CMD_DIVU = 5'd16;
localparam ialu_cmd_t CMD_REM  = 5'd17;
localparam ialu_cmd_t CMD_REMU = 5'd18;

//--------------------------------------------------------------------------
// Connecting structs
//--------------------------------------------------------------------------
typedef struct packed {
    xlen_t op1;                                 // First operand
    xlen_t op2;                                 // Second operand
} ialu_ops_s;

typedef struct packed {
    logic is_div;                               // Any divide or remainder
    logic is_sgn;                               // Signed operands
    logic is_rem;                               // Remainder wanted
} div_req_s;

// Divider FSM states
typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_ITER,
    DIV_CORR
} div_state_e;

typedef struct packed {
    logic ops_nz;                               // Both operands nonzero
    logic corr_req;                             // Correction step needed
} div_status_s;

typedef struct packed {
    xlen_t res;                                 // Divider result
    logic  rdy;                                 // Result valid this cycle
} div_rsp_s;

endpackage : ialu_pkg

/* source/ialu_main.sv */
/*
 * Integer ALU main datapath
 * Add/sub with flags, comparisons, logic ops, shifts, address adder,
 * divide command decode and the final result select
 */
`timescale 1ns/100ps

module ialu_main (
    input  ialu_pkg::ialu_cmd_t cmd_i,          // ALU command
    input  ialu_pkg::ialu_ops_s ops_i,          // Main operands
    input  ialu_pkg::ialu_ops_s addr_ops_i,     // Address operands
    input  ialu_pkg::div_rsp_s  div_rsp_i,      // Divider answer
    output ialu_pkg::xlen_t     res_o,          // Main result
    output logic                cmp_o,          // Comparison bit
    output ialu_pkg::xlen_t     addr_res_o,     // Address adder result
    output logic                res_rdy_o,      // Result ready
    output ialu_pkg::div_req_s  div_req_o       // Decoded divide request
);

import ialu_pkg::*;

typedef struct packed {
    logic z;                                    // Zero
    logic s;                                    // Sign
    logic o;                                    // Overflow
    logic c;                                    // Borrow out
} main_flags_s;

logic [XLEN:0] main_sum;                        // Sum with carry bit
main_flags_s   main_flags;
logic          pos_ovflw;
logic          neg_ovflw;
shamt_t        shamt;
xlen_t         shft_res;

//--------------------------------------------------------------------------
// Main adder and flags
//--------------------------------------------------------------------------
always_comb begin
    main_sum = (cmd_i == CMD_ADD)
             ? ({1'b0, ops_i.op1} + {1'b0, ops_i.op2})
             : ({1'b0, ops_i.op1} - {1'b0, ops_i.op2});   // Sub and compares

    // Subtraction overflow in both directions
    pos_ovflw = ~ops_i.op1[XLEN-1] &  ops_i.op2[XLEN-1] &  main_sum[XLEN-1];
    neg_ovflw =  ops_i.op1[XLEN-1] & ~ops_i.op2[XLEN-1] & ~main_sum[XLEN-1];

    main_flags.c = main_sum[XLEN];
    main_flags.z = ~|main_sum[XLEN-1:0];
    main_flags.s = main_sum[XLEN-1];
    main_flags.o = pos_ovflw | neg_ovflw;
end

//--------------------------------------------------------------------------
// Shifter and address adder
//--------------------------------------------------------------------------
assign shamt = ops_i.op2[4:0];                  // Low five bits only

always_comb begin
    case (cmd_i)
        CMD_SRL : shft_res = ops_i.op1 >> shamt;
        CMD_SRA : shft_res = xlen_t'($signed(ops_i.op1) >>> shamt);  // Sign fill
        default : shft_res = ops_i.op1 << shamt;
    endcase
end

assign addr_res_o = addr_ops_i.op1 + addr_ops_i.op2;

// Divide decode
assign div_req_o.is_div = (cmd_i == CMD_DIV) | (cmd_i == CMD_DIVU)
                        | (cmd_i == CMD_REM) | (cmd_i == CMD_REMU);
assign div_req_o.is_sgn = (cmd_i == CMD_DIV) | (cmd_i == CMD_REM);
assign div_req_o.is_rem = (cmd_i == CMD_REM) | (cmd_i == CMD_REMU);

//--------------------------------------------------------------------------
// Result select
//--------------------------------------------------------------------------
always_comb begin
    res_o     = '0;
    cmp_o     = 1'b0;
    res_rdy_o = 1'b1;                           // Only division waits
    case (cmd_i)
        CMD_ADD, CMD_SUB : res_o = main_sum[XLEN-1:0];
        CMD_AND          : res_o = ops_i.op1 & ops_i.op2;
        CMD_OR           : res_o = ops_i.op1 | ops_i.op2;
        CMD_XOR          : res_o = ops_i.op1 ^ ops_i.op2;
        CMD_LT : begin
            cmp_o = main_flags.s ^ main_flags.o;
            res_o = xlen_t'(cmp_o);
        end
        CMD_GE : begin
            cmp_o = ~(main_flags.s ^ main_flags.o);
            res_o = xlen_t'(cmp_o);
        end
        CMD_LTU : begin
            cmp_o = main_flags.c;               // Borrow means below
            res_o = xlen_t'(cmp_o);
        end
        CMD_GEU : begin
            cmp_o = ~main_flags.c;
            res_o = xlen_t'(cmp_o);
        end
        CMD_EQ : begin
            cmp_o = main_flags.z;
            res_o = xlen_t'(cmp_o);
        end
        CMD_NE : begin
            cmp_o = ~main_flags.z;
            res_o = xlen_t'(cmp_o);
        end
        CMD_SLL, CMD_SRL, CMD_SRA : res_o = shft_res;
        CMD_DIV, CMD_DIVU, CMD_REM, CMD_REMU : begin
            res_o     = div_rsp_i.res;
            res_rdy_o = div_rsp_i.rdy;
        end
        default : begin
        end
    endcase
end

endmodule : ialu_main

/* source/ialu_div_ctrl.sv */
/*
 * Divider control
 * Three-state FSM with a one-hot iteration counter
 */
`timescale 1ns/100ps

module ialu_div_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  div_vd_i,      // Divide command valid
    input  ialu_pkg::div_req_s    div_req_i,     // Decoded request
    input  ialu_pkg::div_status_s div_status_i,  // Datapath flags
    output ialu_pkg::div_state_e  div_state_o,   // Current FSM state
    output logic                  iter_last_o    // Last iteration cycle
);

import ialu_pkg::*;

div_state_e state_ff;
div_state_e state_next;
xlen_t      iter_cnt_ff;                        // One-hot, walks right
xlen_t      iter_cnt_next;
logic       iter_req;                           // Start iterating

assign iter_req    = div_req_i.is_div & div_status_i.ops_nz;
assign iter_last_o = iter_cnt_ff[0];
assign div_state_o = state_ff;

//--------------------------------------------------------------------------
// FSM
//--------------------------------------------------------------------------
always_comb begin
    state_next = DIV_IDLE;                      // Dropped command aborts
    if (div_vd_i) begin
        case (state_ff)
            DIV_IDLE : state_next = iter_req ? DIV_ITER : DIV_IDLE;
            DIV_ITER : begin
                state_next = ~iter_last_o           ? DIV_ITER
                           : div_status_i.corr_req  ? DIV_CORR
                                                    : DIV_IDLE;
            end
            DIV_CORR : state_next = DIV_IDLE;   // Single fixup cycle
            default  : state_next = DIV_IDLE;
        endcase
    end
end

// Counter reloads while idle
always_comb begin
    case (state_ff)
        DIV_IDLE : iter_cnt_next = DIV_CNT_INIT;
        DIV_ITER : iter_cnt_next = iter_cnt_ff >> 1;
        default  : iter_cnt_next = iter_cnt_ff;
    endcase
end

always_ff @(posedge clk, negedge rst_n) begin
    if (~rst_n) begin
        state_ff    <= DIV_IDLE;
        iter_cnt_ff <= DIV_CNT_INIT;
    end else begin
        state_ff    <= state_next;
        iter_cnt_ff <= iter_cnt_next;
    end
end

//--------------------------------------------------------------------------
// Assertions
//--------------------------------------------------------------------------
// Counter must still hold its single bit while iterating
ialu_div_cnt_onehot : assert property (
    @(posedge clk) disable iff (~rst_n)
    (state_ff == DIV_ITER) |-> $onehot(iter_cnt_ff)
) else $error("Divider iteration counter not one-hot");

// Holds only while the pipeline keeps the command valid
ialu_div_iter_hold : assert property (
    @(posedge clk) disable iff (~rst_n)
    ((state_ff == DIV_ITER) & ~iter_last_o) |=> (state_ff == DIV_ITER)
) else $error("Divider left iteration early");

ialu_div_state_known : assert property (
    @(posedge clk) disable iff (~rst_n)
    !$isunknown(state_ff)
) else $error("Divider state unknown");

endmodule : ialu_div_ctrl

/* source/ialu_div_datapath.sv */
/*
 * Divider datapath
 * Non-restoring divide, one quotient bit per cycle, with a final
 * correction step and a shortcut for zero operands
 */
`timescale 1ns/100ps

module ialu_div_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  div_vd_i,      // Divide command valid
    input  ialu_pkg::div_req_s    div_req_i,     // Decoded request
    input  ialu_pkg::ialu_ops_s   ops_i,         // Dividend and divisor
    input  ialu_pkg::div_state_e  div_state_i,   // FSM state
    input  logic                  iter_last_i,   // Last iteration cycle
    output ialu_pkg::div_status_s div_status_o,  // Flags for the FSM
    output ialu_pkg::div_rsp_s    div_rsp_o      // Result and ready
);

import ialu_pkg::*;

logic          op1_neg;                         // Signed and negative
logic          op2_neg;
logic          ops_diff_sgn;
logic          st_idle;
logic          st_corr;

// Divider adder
logic          sum_sgn;
logic          sum_inv;
logic          sum_sub;                         // 1 subtracts divisor
logic [XLEN:0] sum_op1;
logic [XLEN:0] sum_op2;
logic [XLEN:0] sum_res;

// Step values
logic          rem_c;
xlen_t         rem;
logic          quo_bit;
xlen_t         quo_next;
xlen_t         dvdnd_lo_next;
logic          quo_corr;
logic          rem_corr;

// Registers
logic          upd;
logic          rem_c_ff;
xlen_t         rem_ff;
xlen_t         quo_ff;
xlen_t         dvdnd_lo_ff;                     // Dividend bits not yet used

assign op1_neg      = div_req_i.is_sgn & ops_i.op1[XLEN-1];
assign op2_neg      = div_req_i.is_sgn & ops_i.op2[XLEN-1];
assign ops_diff_sgn = ops_i.op1[XLEN-1] ^ ops_i.op2[XLEN-1];
assign st_idle      = (div_state_i == DIV_IDLE);
assign st_corr      = (div_state_i == DIV_CORR);

//--------------------------------------------------------------------------
// Divider adder
//--------------------------------------------------------------------------
always_comb begin
    sum_sgn = st_corr ? (op1_neg ^ rem_c_ff)
            : st_idle ? 1'b0
                      : ~quo_ff[0];             // Previous quotient bit
    sum_inv = div_req_i.is_sgn & ops_diff_sgn;
    sum_sub = ~sum_inv ^ sum_sgn;
    sum_op1 = st_corr ? {1'b0, rem_ff}
            : st_idle ? {{XLEN{op1_neg}}, ops_i.op1[XLEN-1]}   // First dividend bit
                      : {rem_ff, dvdnd_lo_ff[XLEN-1]};
    sum_op2 = {op2_neg, ops_i.op2};
    sum_res = sum_sub ? (sum_op1 - sum_op2) : (sum_op1 + sum_op2);
end

assign rem_c = sum_res[XLEN];
assign rem   = sum_res[XLEN-1:0];

assign dvdnd_lo_next = st_corr ? '0
                     : st_idle ? (ops_i.op1 << 1)
                               : (dvdnd_lo_ff << 1);

// Negative dividend with remainder equal to the divisor also gives a 1
assign quo_bit  = ~(op1_neg ^ rem_c)
                | (op1_neg & ({sum_res, dvdnd_lo_next} == '0));
assign quo_next = st_idle ? xlen_t'(quo_bit) : {quo_ff[XLEN-2:0], quo_bit};

//--------------------------------------------------------------------------
// Status for the FSM
//--------------------------------------------------------------------------
assign quo_corr = ~div_req_i.is_rem & div_req_i.is_sgn & ops_diff_sgn;
assign rem_corr = div_req_i.is_rem & (|rem) & (op1_neg ^ rem_c);   // Sign mismatch

assign div_status_o.ops_nz   = (|ops_i.op1) & (|ops_i.op2);
assign div_status_o.corr_req = div_req_i.is_div & (quo_corr | rem_corr);

//--------------------------------------------------------------------------
// Registers
//--------------------------------------------------------------------------
assign upd = div_vd_i & ~div_rsp_o.rdy;         // Freeze once answered

always_ff @(posedge clk) begin
    if (upd) begin
        rem_c_ff    <= rem_c;
        rem_ff      <= rem;
        quo_ff      <= quo_next;
        dvdnd_lo_ff <= dvdnd_lo_next;
    end
end

// Result and ready
always_comb begin
    div_rsp_o.res = '0;
    div_rsp_o.rdy = 1'b1;
    case (div_state_i)
        DIV_IDLE : begin
            // Zero operand shortcut
            div_rsp_o.res = ((|ops_i.op2) | div_req_i.is_rem) ? ops_i.op1 : '1;
            div_rsp_o.rdy = ~(div_req_i.is_div & div_status_o.ops_nz);
        end
        DIV_ITER : begin
            div_rsp_o.res = div_req_i.is_rem ? rem : quo_next;
            div_rsp_o.rdy = iter_last_i & ~div_status_o.corr_req;
        end
        DIV_CORR : begin
            div_rsp_o.res = div_req_i.is_rem ? rem : -quo_ff;
        end
        default : begin
        end
    endcase
end

ialu_div_inputs_known : assert property (
    @(posedge clk) disable iff (~rst_n)
    div_vd_i |-> !$isunknown({ops_i, div_req_i})
) else $error("Divider inputs unknown while valid");

endmodule : ialu_div_datapath

/* source/ialu_top.sv */
/*
 * Integer ALU top level
 * Main ALU with the iterative divider control and datapath
 */
`timescale 1ns/100ps

module ialu_top (
    input  logic                clk,
    input  logic                rst_n,
    input  ialu_pkg::ialu_cmd_t cmd_i,          // ALU command
    input  ialu_pkg::ialu_ops_s ops_i,          // Main operands
    input  ialu_pkg::ialu_ops_s addr_ops_i,     // Address operands
    input  logic                div_vd_i,       // Divide command valid
    output ialu_pkg::xlen_t     res_o,          // Main result
    output logic                cmp_o,          // Comparison bit
    output ialu_pkg::xlen_t     addr_res_o,     // Address result
    output logic                res_rdy_o       // Result ready
);

import ialu_pkg::*;

div_req_s    div_req;                           // Decoded divide command
div_status_s div_status;
div_state_e  div_state;
logic        iter_last;
div_rsp_s    div_rsp;                           // Divider answer

ialu_main u_main (
    .cmd_i      (cmd_i),
    .ops_i      (ops_i),
    .addr_ops_i (addr_ops_i),
    .div_rsp_i  (div_rsp),
    .res_o      (res_o),
    .cmp_o      (cmp_o),
    .addr_res_o (addr_res_o),
    .res_rdy_o  (res_rdy_o),
    .div_req_o  (div_req)
);

ialu_div_ctrl u_div_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .div_vd_i     (div_vd_i),
    .div_req_i    (div_req),
    .div_status_i (div_status),
    .div_state_o  (div_state),
    .iter_last_o  (iter_last)
);

ialu_div_datapath u_div_datapath (
    .clk          (clk),
    .rst_n        (rst_n),
    .div_vd_i     (div_vd_i),
    .div_req_i    (div_req),
    .ops_i        (ops_i),
    .div_state_i  (div_state),
    .iter_last_i  (iter_last),
    .div_status_o (div_status),
    .div_rsp_o    (div_rsp)
);

endmodule : ialu_top

/* verif/ialu_tb_vectors.svh */
/*
 * Integer ALU fixed test vectors
 * One row per check, applied in order by the testbench table loop
 */
`ifndef IALU_TB_VECTORS_SVH
`define IALU_TB_VECTORS_SVH

// Columns: name, cmd, op1, op2, addr op1, addr op2, exp res, exp cmp, exp addr res
localparam int NUM_VECS = 47;

vec_t vectors [NUM_VECS] = '{
    // Add, sub and logic ops
    '{"add_basic",    CMD_ADD,  'h5,        'h3,        'hFFFFFFF0, 'h20, 'h8,  1'b0, 'h10},
    '{"add_wrap",     CMD_ADD,  'hFFFFFFFF, 'h2,        'h1000, 'h8,  'h1,        1'b0, 'h1008},
    '{"sub_basic",    CMD_SUB,  'h10,       'h3,        'h7FFFFFFF, 'h1,  'hD,  1'b0, 'h80000000},
    '{"sub_wrap",     CMD_SUB,  'h0,        'h1,        'h1000, 'h10, 'hFFFFFFFF, 1'b0, 'h1010},
    '{"and_mix",      CMD_AND,  'hF0F01234, 'h0FF0FF00, 'h1000, 'h14, 'h00F01200, 1'b0, 'h1014},
    '{"or_mix",       CMD_OR,   'hF0F01234, 'h0FF0FF00, 'hFFFFFFFF, 'hFFFFFFFF, 'hFFF0FF34,
      1'b0, 'hFFFFFFFE},
    '{"xor_mix",      CMD_XOR,  'hF0F01234, 'h0FF0FF00, 'h1000, 'h1C, 'hFF00ED34, 1'b0, 'h101C},
    // Signed and unsigned boundaries
    '{"lt_min_one",   CMD_LT,   'h80000000, 'h1,        'h1000, 'h20, 'h1, 1'b1, 'h1020},
    '{"lt_one_min",   CMD_LT,   'h1,        'h80000000, 'h1000, 'h24, 'h0, 1'b0, 'h1024},
    '{"lt_max_neg",   CMD_LT,   'h7FFFFFFF, 'hFFFFFFFF, 'h1000, 'h28, 'h0, 1'b0, 'h1028},
    '{"lt_neg_neg",   CMD_LT,   'hFFFFFFFE, 'hFFFFFFFF, 'h1000, 'h2C, 'h1, 1'b1, 'h102C},
    '{"ltu_min_one",  CMD_LTU,  'h80000000, 'h1,        'h1000, 'h30, 'h0, 1'b0, 'h1030},
    '{"ltu_one_min",  CMD_LTU,  'h1,        'h80000000, 'h1000, 'h34, 'h1, 1'b1, 'h1034},
    '{"ge_equal",     CMD_GE,   'hFFFFFFFF, 'hFFFFFFFF, 'h1000, 'h38, 'h1, 1'b1, 'h1038},
    '{"ge_min_max",   CMD_GE,   'h80000000, 'h7FFFFFFF, 'h1000, 'h3C, 'h0, 1'b0, 'h103C},
    '{"ge_max_min",   CMD_GE,   'h7FFFFFFF, 'h80000000, 'h1000, 'h40, 'h1, 1'b1, 'h1040},
    '{"geu_max_zero", CMD_GEU,  'hFFFFFFFF, 'h0,        'h1000, 'h44, 'h1, 1'b1, 'h1044},
    '{"geu_zero_one", CMD_GEU,  'h0,        'h1,        'h1000, 'h48, 'h0, 1'b0, 'h1048},
    '{"eq_same",      CMD_EQ,   'h12345678, 'h12345678, 'h1000, 'h4C, 'h1, 1'b1, 'h104C},
    '{"eq_diff",      CMD_EQ,   'h12345678, 'h12345679, 'h1000, 'h50, 'h0, 1'b0, 'h1050},
    '{"ne_diff",      CMD_NE,   'h12345678, 'h12345679, 'h1000, 'h54, 'h1, 1'b1, 'h1054},
    '{"ne_same",      CMD_NE,   'h12345678, 'h12345678, 'h1000, 'h58, 'h0, 1'b0, 'h1058},
    // Shifts, amount taken modulo 32
    '{"sll_31",       CMD_SLL,  'h1,        'h1F,       'h1000, 'h5C, 'h80000000, 1'b0, 'h105C},
    '{"sll_mod",      CMD_SLL,  'hF,        'h24,       'h1000, 'h60, 'hF0,       1'b0, 'h1060},
    '{"srl_4",        CMD_SRL,  'h80000000, 'h4,        'h1000, 'h64, 'h08000000, 1'b0, 'h1064},
    '{"sra_neg",      CMD_SRA,  'h80000000, 'h4,        'h1000, 'h68, 'hF8000000, 1'b0, 'h1068},
    '{"sra_mod",      CMD_SRA,  'h70000000, 'h21,       'h1000, 'h6C, 'h38000000, 1'b0, 'h106C},
    // Division, all sign combinations of 100 and 7
    '{"div_pp",       CMD_DIV,  'h64,       'h7,        'h1000, 'h70, 'hE,        1'b0, 'h1070},
    '{"div_np",       CMD_DIV,  'hFFFFFF9C, 'h7,        'h1000, 'h74, 'hFFFFFFF2, 1'b0, 'h1074},
    '{"div_pn",       CMD_DIV,  'h64,       'hFFFFFFF9, 'h1000, 'h78, 'hFFFFFFF2, 1'b0, 'h1078},
    '{"div_nn",       CMD_DIV,  'hFFFFFF9C, 'hFFFFFFF9, 'h1000, 'h7C, 'hE,        1'b0, 'h107C},
    '{"rem_pp",       CMD_REM,  'h64,       'h7,        'h1000, 'h80, 'h2,        1'b0, 'h1080},
    '{"rem_np",       CMD_REM,  'hFFFFFF9C, 'h7,        'h1000, 'h84, 'hFFFFFFFE, 1'b0, 'h1084},
    '{"rem_pn",       CMD_REM,  'h64,       'hFFFFFFF9, 'h1000, 'h88, 'h2,        1'b0, 'h1088},
    '{"rem_nn",       CMD_REM,  'hFFFFFF9C, 'hFFFFFFF9, 'h1000, 'h8C, 'hFFFFFFFE, 1'b0, 'h108C},
    '{"divu_big",     CMD_DIVU, 'hFFFFFFFF, 'h10,       'h1000, 'h90, 'h0FFFFFFF, 1'b0, 'h1090},
    '{"remu_big",     CMD_REMU, 'hFFFFFFFF, 'h10,       'h1000, 'h94, 'hF,        1'b0, 'h1094},
    // Zero operands
    '{"div_by_zero",  CMD_DIV,  'h1234,     'h0,        'h1000, 'h98, 'hFFFFFFFF, 1'b0, 'h1098},
    '{"rem_by_zero",  CMD_REM,  'h1234,     'h0,        'h1000, 'h9C, 'h1234,     1'b0, 'h109C},
    '{"divu_by_zero", CMD_DIVU, 'h5,        'h0,        'h1000, 'hA0, 'hFFFFFFFF, 1'b0, 'h10A0},
    '{"remu_by_zero", CMD_REMU, 'h5,        'h0,        'h1000, 'hA4, 'h5,        1'b0, 'h10A4},
    '{"div_zero_dvd", CMD_DIV,  'h0,        'h5,        'h1000, 'hA8, 'h0,        1'b0, 'h10A8},
    '{"rem_zero_dvd", CMD_REM,  'h0,        'h5,        'h1000, 'hAC, 'h0,        1'b0, 'h10AC},
    // Overflow and exact negative quotient
    '{"div_ovflw",    CMD_DIV,  'h80000000, 'hFFFFFFFF, 'h1000, 'hB0, 'h80000000, 1'b0, 'h10B0},
    '{"rem_ovflw",    CMD_REM,  'h80000000, 'hFFFFFFFF, 'h1000, 'hB4, 'h0,        1'b0, 'h10B4},
    '{"div_exact_ng", CMD_DIV,  'hFFFFFFF4, 'h4,        'h1000, 'hB8, 'hFFFFFFFD, 1'b0, 'h10B8},
    '{"rem_exact_ng", CMD_REM,  'hFFFFFFF4, 'h4,        'h1000, 'hBC, 'h0,        1'b0, 'h10BC}
};

`endif

/* verif/ialu_tb.sv */
/*
 * Integer ALU testbench
 * Fixed table of ALU and divide checks, then random divisions
 * checked against the RISC-V division rules
 */
`timescale 1ns/100ps

module ialu_tb;

import ialu_pkg::*;

localparam int NUM_RAND     = 200;              // Random divisions
localparam int DIV_WAIT_MAX = 40;               // Cycles allowed per divide

typedef struct {
    string     name;
    ialu_cmd_t cmd;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     aop1;                            // Address operands
    xlen_t     aop2;
    xlen_t     res;                             // Expected values
    logic      cmp;
    xlen_t     ares;
} vec_t;

`include "ialu_tb_vectors.svh"

localparam int CYCLE_LIMIT = 40 * NUM_VECS + 40 * NUM_RAND + 20;

logic        clk;
logic        rst_n;
ialu_cmd_t   cmd;
ialu_ops_s   ops;
ialu_ops_s   addr_ops;
logic        div_vd;
xlen_t       res;
logic        cmp;
xlen_t       addr_res;
logic        res_rdy;

int          cycle_cnt  = 0;
logic [31:0] rand_state = 32'h963a2835;         // Xorshift state
ialu_cmd_t   div_cmds [4] = '{CMD_DIV, CMD_DIVU, CMD_REM, CMD_REMU};

ialu_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_i      (cmd),
    .ops_i      (ops),
    .addr_ops_i (addr_ops),
    .div_vd_i   (div_vd),
    .res_o      (res),
    .cmp_o      (cmp),
    .addr_res_o (addr_res),
    .res_rdy_o  (res_rdy)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                      // 10 ns period
end

// Run length guard
always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
        abort_run($sformatf("Timeout, tests still running after %0d cycles", cycle_cnt));
    end
end

//--------------------------------------------------------------------------
// Checks and reference model
//--------------------------------------------------------------------------
task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Run stopped on first error");
endtask

task automatic check_word(input string name, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
        abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
        abort_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    end
endtask

function automatic logic [31:0] next_rand(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// RISC-V divide and remainder rules
function automatic xlen_t div_expect(input ialu_cmd_t op_cmd, input xlen_t a, input xlen_t b);
    logic signed [XLEN-1:0] sa;
    logic signed [XLEN-1:0] sb;
    logic                   want_rem;
    logic                   sgn;
    sa       = a;
    sb       = b;
    want_rem = (op_cmd == CMD_REM) || (op_cmd == CMD_REMU);
    sgn      = (op_cmd == CMD_DIV) || (op_cmd == CMD_REM);
    if (b == '0) return want_rem ? a : '1;      // Zero divisor
    if (sgn && (a == 32'h80000000) && (b == '1)) return want_rem ? '0 : a;
    if (sgn) return want_rem ? xlen_t'(sa % sb) : xlen_t'(sa / sb);   // Truncates to zero
    return want_rem ? (a % b) : (a / b);
endfunction

//--------------------------------------------------------------------------
// Drive one command and check the answer
//--------------------------------------------------------------------------
task automatic run_op(
    input string     name,
    input ialu_cmd_t op_cmd,
    input xlen_t     op1,
    input xlen_t     op2,
    input xlen_t     aop1,
    input xlen_t     aop2,
    input xlen_t     exp_res,
    input logic      exp_cmp,
    input xlen_t     exp_ares
);
    int   waited;
    logic is_dv;
    is_dv  = op_cmd inside {CMD_DIV, CMD_DIVU, CMD_REM, CMD_REMU};
    waited = 0;
    @(posedge clk);
    cmd          <= op_cmd;
    ops.op1      <= op1;
    ops.op2      <= op2;
    addr_ops.op1 <= aop1;
    addr_ops.op2 <= aop2;
    div_vd       <= is_dv;                      // Held until ready
    @(negedge clk);
    if (!is_dv) begin
        check_bit({name, " ready"}, 1'b1, res_rdy);
    end
    while (!res_rdy) begin
        if (waited == DIV_WAIT_MAX) begin
            abort_run($sformatf("%s: divider not ready within %0d cycles", name, waited));
        end
        waited++;
        @(negedge clk);
    end
    check_word(name, exp_res, res);
    check_bit({name, " cmp"}, exp_cmp, cmp);
    check_word({name, " addr"}, exp_ares, addr_res);
endtask

//--------------------------------------------------------------------------
// Main sequence
//--------------------------------------------------------------------------
initial begin
    xlen_t     dvdnd;
    xlen_t     dvsr;
    ialu_cmd_t dcmd;
    cmd      <= CMD_NONE;
    ops      <= '0;
    addr_ops <= '0;
    div_vd   <= 1'b0;
    rst_n    <= 1'b0;
    repeat (5) @(posedge clk);
    rst_n    <= 1'b1;

    for (int i = 0; i < NUM_VECS; i++) begin
        run_op(vectors[i].name, vectors[i].cmd, vectors[i].op1, vectors[i].op2,
               vectors[i].aop1, vectors[i].aop2, vectors[i].res, vectors[i].cmp,
               vectors[i].ares);
    end

    for (int i = 0; i < NUM_RAND; i++) begin
        rand_state = next_rand(rand_state);
        dvdnd      = rand_state;
        rand_state = next_rand(rand_state);
        dvsr       = rand_state;
        rand_state = next_rand(rand_state);
        dvdnd      = xlen_t'($signed(dvdnd) >>> rand_state[4:0]);   // Spread magnitudes
        dvsr       = xlen_t'($signed(dvsr) >>> rand_state[9:5]);
        dcmd       = div_cmds[rand_state[11:10]];
        run_op($sformatf("rand_div_%0d", i), dcmd, dvdnd, dvsr, dvdnd, dvsr,
               div_expect(dcmd, dvdnd, dvsr), 1'b0, dvdnd + dvsr);
        // Plain add in between, ready at once
        run_op($sformatf("rand_gap_%0d", i), CMD_ADD, dvsr, dvdnd, '0, '0,
               dvsr + dvdnd, 1'b0, '0);
    end

    @(posedge clk);
    div_vd <= 1'b0;
    cmd    <= CMD_NONE;
    $display("Simulation passed");
    $finish;
end

endmodule : ialu_tb

/* src.f */
+incdir+verif
source/ialu_pkg.sv
source/ialu_main.sv
source/ialu_div_ctrl.sv
source/ialu_div_datapath.sv
source/ialu_top.sv
verif/ialu_tb.sv

/* Makefile */
# Verilator build, run, lint and clean for the integer ALU

VERILATOR  ?= verilator
TOP        ?= ialu_tb
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE) -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --timescale $(TIMESCALE)
SIM_BIN    ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Exit status of the simulation is the result
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
